// ==== list.f ====
+incdir+include
hdl/fft_pkg.sv
hdl/fft_ifs.sv
hdl/fft_loader.sv
hdl/fft_butterfly.sv
hdl/fft_engine.sv
hdl/fft_unloader.sv
hdl/fft_top.sv
dv/tb_clock_gen.sv
dv/fft_tb.sv

// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert \
		-f list.f \
		--top-module fft_tb \
		-o fft_sim \
	&& ./obj_dir/fft_sim | tee /dev/stderr | grep -qx "Test OK" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== dv/fft_tb.sv ====
`default_nettype none

`include "fft_defs.svh"

module fft_tb;
	import fft_pkg::*;

	localparam int RESET_CYCLES    = 16;
	localparam int NUM_FRAMES      = 7;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_FRAMES * 200;

	// W16^m scaled by 256
	localparam int TW_RE [8] = '{256, 237, 181, 98, 0, -98, -181, -237};
	localparam int TW_IM [8] = '{0, -98, -181, -237, -256, -237, -181, -98};

	logic    clk;
	logic    arst_n;
	logic    in_valid;
	logic    in_ready;
	sample_t in_re;
	sample_t in_im;
	logic    out_valid;
	logic    out_ready;
	sample_t out_re;
	sample_t out_im;
	logic    out_last;

	cpx_t        frame_in   [`FFT_POINTS];
	cpx_t        expect_out [`FFT_POINTS];
	int          error_count = 0;
	int          check_count = 0;
	int unsigned lcg_state   = 32'd11;

	tb_clock_gen u_clk (
		.o_clk (clk)
	);

	fft_top dut (
		.i_clk       (clk),
		.i_arst_n    (arst_n),
		.i_in_valid  (in_valid),
		.o_in_ready  (in_ready),
		.i_in_re     (in_re),
		.i_in_im     (in_im),
		.o_out_valid (out_valid),
		.i_out_ready (out_ready),
		.o_out_re    (out_re),
		.o_out_im    (out_im),
		.o_out_last  (out_last)
	);

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// uniform in -127..127
	function automatic sample_t rand_part();
		int unsigned r;
		r = lcg_next();
		return sample_t'(int'((r >> 16) % 255) - 127);
	endfunction

	function automatic int bit_reverse4(input int n);
		return ((n & 1) << 3) | ((n & 2) << 1) | ((n & 4) >> 1) | ((n & 8) >> 3);
	endfunction

	task automatic check_cpx(input string name, input cpx_t got, input cpx_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("CHECK FAILED t=%0t %s: got (%0d,%0d) expected (%0d,%0d)",
				$time, name, got.re, got.im, exp.re, exp.im);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("CHECK FAILED t=%0t %s: got %b expected %b", $time, name, got, exp);
		end
	endtask

	// DIT order, floor shift and wrap, one butterfly at a time
	task automatic compute_reference();
		cpx_t    work [`FFT_POINTS];
		cpx_t    a;
		sample_t t_re, t_im;
		int      span, k, lo, hi, m, p_re, p_im;
		for (int n = 0; n < `FFT_POINTS; n++) begin
			work[bit_reverse4(n)] = frame_in[n];
		end
		for (int s = 0; s < `FFT_STAGES; s++) begin
			for (int j = 0; j < `FFT_POINTS / 2; j++) begin
				span = 1 << s;
				k    = j % span;
				lo   = (j / span) * 2 * span + k;
				hi   = lo + span;
				m    = k << (3 - s);
				p_re = int'(work[hi].re) * TW_RE[m] - int'(work[hi].im) * TW_IM[m];
				p_im = int'(work[hi].re) * TW_IM[m] + int'(work[hi].im) * TW_RE[m];
				t_re = sample_t'(p_re >>> `FFT_FRAC);
				t_im = sample_t'(p_im >>> `FFT_FRAC);
				a    = work[lo];
				work[lo].re = sample_t'(int'(a.re) + int'(t_re));
				work[lo].im = sample_t'(int'(a.im) + int'(t_im));
				work[hi].re = sample_t'(int'(a.re) - int'(t_re));
				work[hi].im = sample_t'(int'(a.im) - int'(t_im));
			end
		end
		for (int n = 0; n < `FFT_POINTS; n++) begin
			expect_out[n] = work[n];
		end
	endtask

	task automatic apply_reset();
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	endtask

	task automatic send_frame();
		@(negedge clk);
		for (int n = 0; n < `FFT_POINTS; n++) begin
			in_valid = 1'b1;
			in_re    = frame_in[n].re;
			in_im    = frame_in[n].im;
			while (!in_ready) begin
				@(negedge clk);
			end
			// transfer on the rising edge in between
			@(negedge clk);
		end
		in_valid = 1'b0;
	endtask

	task automatic collect_frame(input int stall_pct, input bit ready_low);
		int   idx;
		bit   holding;
		cpx_t got;
		cpx_t held;
		idx     = 0;
		holding = 1'b0;
		while (idx < `FFT_POINTS) begin
			@(negedge clk);
			got.re = out_re;
			got.im = out_im;
			if (holding) begin
				check_flag("o_out_valid", out_valid, 1'b1);
				check_cpx("o_out_re/o_out_im held", got, held);
			end
			if (ready_low) begin
				check_flag("o_in_ready", in_ready, 1'b0);
			end
			if (stall_pct > 0) begin
				out_ready = (int'(lcg_next() >> 8) % 100) >= stall_pct;
			end else begin
				out_ready = 1'b1;
			end
			holding = out_valid && !out_ready;
			held    = got;
			if (out_valid && out_ready) begin
				check_cpx($sformatf("o_out_re/o_out_im[%0d]", idx), got, expect_out[idx]);
				check_flag("o_out_last", out_last, idx == `FFT_POINTS - 1);
				idx++;
			end
		end
	endtask

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	task automatic after_reset_idle();
		@(negedge clk);
		check_flag("o_out_valid", out_valid, 1'b0);
		check_flag("o_in_ready", in_ready, 1'b1);
	endtask

	task automatic impulse_frame();
		for (int n = 0; n < `FFT_POINTS; n++) begin
			frame_in[n]   = '{re: sample_t'(0), im: sample_t'(0)};
			expect_out[n] = '{re: sample_t'(100), im: sample_t'(0)};
		end
		frame_in[0] = '{re: sample_t'(100), im: sample_t'(0)};
		send_frame();
		collect_frame(0, 1'b0);
	endtask

	task automatic constant_frame();
		for (int n = 0; n < `FFT_POINTS; n++) begin
			frame_in[n]   = '{re: sample_t'(20), im: sample_t'(-10)};
			expect_out[n] = '{re: sample_t'(0), im: sample_t'(0)};
		end
		expect_out[0] = '{re: sample_t'(320), im: sample_t'(-160)};
		send_frame();
		collect_frame(0, 1'b0);
	endtask

	task automatic random_frames(input int count);
		for (int f = 0; f < count; f++) begin
			for (int n = 0; n < `FFT_POINTS; n++) begin
				frame_in[n].re = rand_part();
				frame_in[n].im = rand_part();
			end
			compute_reference();
			send_frame();
			collect_frame(0, 1'b0);
		end
	endtask

	// two frames back to back under output stalls
	task automatic stalled_output();
		for (int f = 0; f < 2; f++) begin
			for (int n = 0; n < `FFT_POINTS; n++) begin
				frame_in[n].re = rand_part();
				frame_in[n].im = rand_part();
			end
			compute_reference();
			send_frame();
			collect_frame(60, 1'b1);
		end
	endtask

	initial begin
		arst_n    = 1'b0;
		in_valid  = 1'b0;
		in_re     = '0;
		in_im     = '0;
		out_ready = 1'b0;
		apply_reset();
		after_reset_idle();
		impulse_frame();
		constant_frame();
		random_frames(3);
		stalled_output();
		repeat (4) @(negedge clk);
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	// budget of 200 cycles per frame
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: the frames did not complete within %0d cycles", WATCHDOG_CYCLES);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
	output logic o_clk
);

	// period 40
	localparam int HALF_PERIOD = 20;

	initial begin
		o_clk = 1'b0;
		forever begin
			#HALF_PERIOD o_clk = ~o_clk;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/fft_top.sv ====
`default_nettype none

module fft_top (
	input  logic             i_clk,
	input  logic             i_arst_n,

	// sample input stream
	input  logic             i_in_valid,
	output logic             o_in_ready,
	input  fft_pkg::sample_t i_in_re,
	input  fft_pkg::sample_t i_in_im,

	// result output stream
	output logic             o_out_valid,
	input  logic             i_out_ready,
	output fft_pkg::sample_t o_out_re,
	output fft_pkg::sample_t o_out_im,
	output logic             o_out_last
);

	fft_load_if u_load_if ();
	fft_read_if u_read_if ();

	fft_loader u_loader (
		.i_clk      (i_clk),
		.i_arst_n   (i_arst_n),
		.i_in_valid (i_in_valid),
		.o_in_ready (o_in_ready),
		.i_in_re    (i_in_re),
		.i_in_im    (i_in_im),
		.ld         (u_load_if.loader)
	);

	fft_engine u_engine (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.ld       (u_load_if.engine),
		.rd       (u_read_if.engine)
	);

	fft_unloader u_unloader (
		.i_clk       (i_clk),
		.i_arst_n    (i_arst_n),
		.rd          (u_read_if.unloader),
		.o_out_valid (o_out_valid),
		.i_out_ready (i_out_ready),
		.o_out_re    (o_out_re),
		.o_out_im    (o_out_im),
		.o_out_last  (o_out_last)
	);

endmodule

`default_nettype wire

// ==== hdl/fft_unloader.sv ====
`default_nettype none

`include "fft_defs.svh"

module fft_unloader (
	input  logic             i_clk,
	input  logic             i_arst_n,
	fft_read_if.unloader     rd,
	output logic             o_out_valid,
	input  logic             i_out_ready,
	output fft_pkg::sample_t o_out_re,
	output fft_pkg::sample_t o_out_im,
	output logic             o_out_last
);
	import fft_pkg::*;

	addr_t rd_addr_q;
	logic  all_fetched;
	logic  done_q;
	logic  fire;
	logic  fetch;
	cpx_t  out_q;

	assign rd.rd_addr = rd_addr_q;
	assign rd.done    = done_q;

	assign fire  = o_out_valid && i_out_ready;
	// refill when the output register is empty or being drained
	assign fetch = rd.open && !all_fetched && (!o_out_valid || i_out_ready);

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			rd_addr_q   <= '0;
			all_fetched <= 1'b0;
			done_q      <= 1'b0;
			o_out_valid <= 1'b0;
			o_out_last  <= 1'b0;
		end else begin
			done_q <= fire && o_out_last;
			if (fetch) begin
				rd_addr_q   <= rd_addr_q + addr_t'(1);
				o_out_valid <= 1'b1;
				o_out_last  <= (rd_addr_q == addr_t'(`FFT_POINTS - 1));
				if (rd_addr_q == addr_t'(`FFT_POINTS - 1)) begin
					all_fetched <= 1'b1;
				end
			end else if (fire) begin
				o_out_valid <= 1'b0;
				o_out_last  <= 1'b0;
			end
			// frame handed back to the loader
			if (done_q) begin
				all_fetched <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (fetch) begin
			out_q <= rd.rd_data;
		end
	end

	assign o_out_re = out_q.re;
	assign o_out_im = out_q.im;

	// stalled output keeps its word
	a_hold_stall : assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		o_out_valid && !i_out_ready |=> o_out_valid && $stable(out_q) && $stable(o_out_last)
	);

endmodule

`default_nettype wire

// ==== hdl/fft_engine.sv ====
`default_nettype none

`include "fft_defs.svh"

module fft_engine (
	input  logic       i_clk,
	input  logic       i_arst_n,
	fft_load_if.engine ld,
	fft_read_if.engine rd
);
	import fft_pkg::*;

	engine_state_e state;
	cpx_t          bank [`FFT_POINTS];

	logic [1:0] stage;
	logic [2:0] pair;
	logic       gap;
	logic       issue;

	addr_t   span, k, lo, hi;
	tw_idx_t tw_idx;
	cpx_t    tw;

	addr_t wb_lo, wb_hi;
	cpx_t  bf_sum, bf_diff;
	logic  bf_valid;

	assign ld.open    = (state == ST_LOAD);
	assign rd.open    = (state == ST_UNLOAD);
	assign rd.rd_data = bank[rd.rd_addr];

	////////////////////////////////////////
	// sequencing
	////////////////////////////////////////

	// 8 butterflies then one idle slot per stage
	assign issue = (state == ST_COMPUTE) && !gap;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= ST_LOAD;
			stage <= '0;
			pair  <= '0;
			gap   <= 1'b0;
		end else begin
			case (state)
				ST_LOAD: begin
					if (ld.wr_en && ld.last) begin
						state <= ST_COMPUTE;
					end
				end
				ST_COMPUTE: begin
					if (gap) begin
						gap   <= 1'b0;
						stage <= stage + 2'd1;
						if (stage == 2'(`FFT_STAGES - 1)) begin
							state <= ST_UNLOAD;
						end
					end else begin
						pair <= pair + 3'd1;
						if (pair == 3'd7) begin
							gap <= 1'b1;
						end
					end
				end
				ST_UNLOAD: begin
					if (rd.done) begin
						state <= ST_LOAD;
					end
				end
				default: state <= ST_LOAD;
			endcase
		end
	end

	////////////////////////////////////////
	// addressing and twiddles
	////////////////////////////////////////

	always_comb begin
		span   = addr_t'(1) << stage;
		k      = {1'b0, pair} & (span - addr_t'(1));
		lo     = (({1'b0, pair} - k) << 1) | k;
		hi     = lo | span;
		tw_idx = tw_idx_t'(k << (2'd3 - stage));
	end

	// W16^m scaled by 256
	always_comb begin
		case (tw_idx)
			3'd0: tw = '{re: 16'sd256,  im: 16'sd0};
			3'd1: tw = '{re: 16'sd237,  im: -16'sd98};
			3'd2: tw = '{re: 16'sd181,  im: -16'sd181};
			3'd3: tw = '{re: 16'sd98,   im: -16'sd237};
			3'd4: tw = '{re: 16'sd0,    im: -16'sd256};
			3'd5: tw = '{re: -16'sd98,  im: -16'sd237};
			3'd6: tw = '{re: -16'sd181, im: -16'sd181};
			default: tw = '{re: -16'sd237, im: -16'sd98};
		endcase
	end

	fft_butterfly u_bf (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_issue  (issue),
		.i_a      (bank[lo]),
		.i_b      (bank[hi]),
		.i_w      (tw),
		.o_sum    (bf_sum),
		.o_diff   (bf_diff),
		.o_valid  (bf_valid)
	);

	////////////////////////////////////////
	// sample bank
	////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (issue) begin
			wb_lo <= lo;
			wb_hi <= hi;
		end
		if (ld.wr_en) begin
			bank[ld.wr_addr] <= ld.wr_data;
		end
		// write back one cycle behind the issue
		if (bf_valid) begin
			bank[wb_lo] <= bf_sum;
			bank[wb_hi] <= bf_diff;
		end
	end

	// unloader hands the bank back only while unloading
	a_done_in_unload : assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		rd.done |-> (state == ST_UNLOAD)
	);

	// write-backs drain before the results are read out
	a_wb_in_compute : assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		bf_valid |-> (state == ST_COMPUTE)
	);

endmodule

`default_nettype wire

// ==== hdl/fft_butterfly.sv ====
`default_nettype none

`include "fft_defs.svh"

module fft_butterfly (
	input  logic          i_clk,
	input  logic          i_arst_n,
	input  logic          i_issue,
	input  fft_pkg::cpx_t i_a,
	input  fft_pkg::cpx_t i_b,
	input  fft_pkg::cpx_t i_w,
	output fft_pkg::cpx_t o_sum,
	output fft_pkg::cpx_t o_diff,
	output logic          o_valid
);
	import fft_pkg::*;

	sample_t b_re, b_im, w_re, w_im;
	sample_t t_re, t_im;
	logic signed [2*`FFT_WIDTH:0] p_re, p_im;

	assign b_re = i_b.re;
	assign b_im = i_b.im;
	assign w_re = i_w.re;
	assign w_im = i_w.im;

	// full width complex product b*w
	assign p_re = b_re * w_re - b_im * w_im;
	assign p_im = b_re * w_im + b_im * w_re;

	// floor shift by the fraction bits, then wrap
	assign t_re = p_re[`FFT_FRAC +: `FFT_WIDTH];
	assign t_im = p_im[`FFT_FRAC +: `FFT_WIDTH];

	always_ff @(posedge i_clk) begin
		if (i_issue) begin
			o_sum.re  <= i_a.re + t_re;
			o_sum.im  <= i_a.im + t_im;
			o_diff.re <= i_a.re - t_re;
			o_diff.im <= i_a.im - t_im;
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_issue;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/fft_loader.sv ====
`default_nettype none

`include "fft_defs.svh"

module fft_loader (
	input  logic             i_clk,
	input  logic             i_arst_n,
	input  logic             i_in_valid,
	output logic             o_in_ready,
	input  fft_pkg::sample_t i_in_re,
	input  fft_pkg::sample_t i_in_im,
	fft_load_if.loader       ld
);
	import fft_pkg::*;

	addr_t cnt;
	logic  accept;

	function automatic addr_t bit_rev(input addr_t a);
		addr_t r;
		for (int i = 0; i < `FFT_STAGES; i++) begin
			r[i] = a[`FFT_STAGES-1-i];
		end
		return r;
	endfunction

	assign o_in_ready = ld.open;
	assign accept     = i_in_valid && ld.open;

	// each accepted sample goes straight into the bank
	assign ld.wr_en      = accept;
	assign ld.wr_addr    = bit_rev(cnt);
	assign ld.wr_data.re = i_in_re;
	assign ld.wr_data.im = i_in_im;
	assign ld.last       = accept && (cnt == addr_t'(`FFT_POINTS - 1));

	// sample counter, wraps after a full frame
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			cnt <= '0;
		end else if (accept) begin
			cnt <= cnt + addr_t'(1);
		end
	end

	// bank stays open until the last write of a frame
	a_open_whole_frame : assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		ld.wr_en && !ld.last |=> ld.open
	);

endmodule

`default_nettype wire

// ==== hdl/fft_ifs.sv ====
`default_nettype none

// loader writes samples into the engine bank
interface fft_load_if;
	import fft_pkg::*;

	logic  open;
	logic  wr_en;
	addr_t wr_addr;
	cpx_t  wr_data;
	logic  last;

	modport loader (
		input  open,
		output wr_en,
		output wr_addr,
		output wr_data,
		output last
	);

	modport engine (
		output open,
		input  wr_en,
		input  wr_addr,
		input  wr_data,
		input  last
	);
endinterface

// unloader reads results out of the engine bank
interface fft_read_if;
	import fft_pkg::*;

	logic  open;
	addr_t rd_addr;
	cpx_t  rd_data;
	logic  done;

	modport engine (
		output open,
		input  rd_addr,
		output rd_data,
		input  done
	);

	modport unloader (
		input  open,
		output rd_addr,
		input  rd_data,
		output done
	);
endinterface

`default_nettype wire

// ==== hdl/fft_pkg.sv ====
`default_nettype none

`include "fft_defs.svh"

package fft_pkg;

	// one real or imaginary part
	typedef logic signed [`FFT_WIDTH-1:0] sample_t;

	typedef struct packed {
		sample_t re;
		sample_t im;
	} cpx_t;

	// bank address and twiddle table index
	typedef logic [`FFT_STAGES-1:0] addr_t;
	typedef logic [`FFT_STAGES-2:0] tw_idx_t;

	typedef enum logic [1:0] {
		ST_LOAD,
		ST_COMPUTE,
		ST_UNLOAD
	} engine_state_e;

endpackage

`default_nettype wire

// ==== include/fft_defs.svh ====
`ifndef FFT_DEFS_SVH
`define FFT_DEFS_SVH

// transform size
`define FFT_POINTS 16
`define FFT_STAGES 4

// fixed point format, same for samples and twiddles
`define FFT_WIDTH 16
`define FFT_FRAC 8

`endif
